// ==== files.f ====
hw/hps_pkg.sv
hw/cmd_decode.sv
hw/word_assembler.sv
hw/ps2_key_decode.sv
hw/file_loader.sv
hw/status_readback.sv
hw/hps_io_core.sv
verif/hps_io_asserts.sv
verif/tb_hps_io.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_hps_io
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_hps_io +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	exit 1
fi
exit 0

// ==== verif/tb_hps_io.sv ====
// testbench for the command-port core with 8-bit download data
// host frames are driven on falling edges, strobes 4 cycles apart
// responses are read just before the next strobe would go out
module tb_hps_io;

	logic               clk_sys;
	logic               arst_n;
	hps_pkg::host_bus_s host;
	hps_pkg::word_t     host_dout;
	hps_pkg::joy_t      joystick_0;
	hps_pkg::joy_t      joystick_1;
	hps_pkg::status_t   status;
	hps_pkg::status_t   status_in;
	logic               status_set;
	hps_pkg::ps2_key_s  ps2_key;
	logic               ioctl_download;
	hps_pkg::word_t     ioctl_index;
	logic               ioctl_wr;
	logic [26:0]        ioctl_addr;
	logic [7:0]         ioctl_dout;

	logic [31:0]    seed = 32'd33;
	int             checks;
	int             errors;
	int             timeouts;
	logic           key_toggle;
	hps_pkg::word_t frame_words[$];
	hps_pkg::word_t resp_words[$];
	logic [26:0]    wr_addr[$];
	logic [7:0]     wr_dout[$];

	hps_io_core #(.DATA_W(8)) hps_io_core_i (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.host           (host),
		.host_dout      (host_dout),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.status         (status),
		.status_in      (status_in),
		.status_set     (status_set),
		.ps2_key        (ps2_key),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// write pulses last one full cycle, so one sample each
	always @(negedge clk_sys) begin
		if (ioctl_wr) begin
			wr_addr.push_back(ioctl_addr);
			wr_dout.push_back(ioctl_dout);
		end
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic hps_pkg::word_t random_word();
		logic [31:0] r;
		r = next_random();
		return r[23:8];
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	////////////////////
	// host frames
	////////////////////
	task automatic send_word(input hps_pkg::word_t w, output hps_pkg::word_t resp);
		@(negedge clk_sys);
		host.strobe = 1'b1;
		host.din    = w;
		@(negedge clk_sys);
		host.strobe = 1'b0;
		repeat (2) @(negedge clk_sys);
		resp = host_dout;
	endtask

	// sends frame_words, the first one being the command
	task automatic send_frame(input logic file_frame);
		hps_pkg::word_t resp;
		resp_words.delete();
		@(negedge clk_sys);
		host.io_enable = ~file_frame;
		host.fp_enable = file_frame;
		foreach (frame_words[i]) begin
			send_word(frame_words[i], resp);
			resp_words.push_back(resp);
		end
		@(negedge clk_sys);
		host.io_enable = 1'b0;
		host.fp_enable = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic start_frame(input hps_pkg::word_t cmd);
		frame_words.delete();
		frame_words.push_back(cmd);
	endtask

	////////////////////
	// waits
	////////////////////
	task automatic wait_toggle(input logic want);
		int n;
		n = 0;
		while (ps2_key.toggle !== want && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (ps2_key.toggle !== want) begin
			$display("timed out waiting for a key event");
			timeouts++;
			end_run();
		end
	endtask

	task automatic wait_writes(input int count);
		int n;
		n = 0;
		while (wr_addr.size() < count && n < 50) begin
			@(negedge clk_sys);
			n++;
		end
		if (wr_addr.size() < count) begin
			$display("timed out waiting for download write pulses");
			timeouts++;
			end_run();
		end
	endtask

	// bytes are sent oldest first, fields are {pressed, extended, code}
	task automatic key_case(input string name, input logic [31:0] bytes, input int n,
		input logic [9:0] fields);
		logic [31:0] b;
		start_frame(hps_pkg::CMD_KBD);
		for (int i = n - 1; i >= 0; i--) begin
			b = bytes >> (8 * i);
			frame_words.push_back({8'h00, b[7:0]});
		end
		send_frame(1'b0);
		key_toggle = ~key_toggle;
		wait_toggle(key_toggle);
		check_value(name, 128'({key_toggle, fields}), 128'(ps2_key));
	endtask

	task automatic end_run();
		int assert_fails;
		assert_fails = hps_io_core_i.hps_io_asserts_i.fail_count;
		$display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, assert_fails);
		if (errors == 0 && timeouts == 0 && assert_fails == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	initial begin
		hps_pkg::joy_t    exp_joy0;
		hps_pkg::status_t exp_status;
		hps_pkg::word_t   rw;
		checks     = 0;
		errors     = 0;
		timeouts   = 0;
		key_toggle = 1'b0;
		arst_n     = 1'b0;
		host       = '0;
		status_in  = '0;
		status_set = 1'b0;
		repeat (8) @(negedge clk_sys);
		arst_n = 1'b1;
		repeat (2) @(negedge clk_sys);

		// joysticks, high word above low word
		start_frame(hps_pkg::CMD_JOY0);
		frame_words.push_back(random_word());
		frame_words.push_back(random_word());
		send_frame(1'b0);
		exp_joy0 = {frame_words[2], frame_words[1]};
		check_value("joystick_0", 128'(exp_joy0), 128'(joystick_0));
		check_value("joystick_1 untouched", 128'd0, 128'(joystick_1));
		start_frame(hps_pkg::CMD_JOY1);
		frame_words.push_back(random_word());
		frame_words.push_back(random_word());
		send_frame(1'b0);
		check_value("joystick_1", 128'({frame_words[2], frame_words[1]}), 128'(joystick_1));
		check_value("joystick_0 untouched", 128'(exp_joy0), 128'(joystick_0));

		// status, first word lowest
		start_frame(hps_pkg::CMD_STATUS);
		for (int i = 0; i < 8; i++)
			frame_words.push_back(random_word());
		send_frame(1'b0);
		exp_status = '0;
		for (int i = 1; i <= 8; i++)
			exp_status = {frame_words[i], exp_status[127:16]};
		check_value("status", exp_status, status);

		// status change request and readback
		@(negedge clk_sys);
		status_in  = {next_random(), next_random(), next_random(), next_random()};
		status_set = 1'b1;
		@(negedge clk_sys);
		status_set = 1'b0;
		start_frame(hps_pkg::CMD_STATUS_REQ);
		for (int i = 0; i < 8; i++)
			frame_words.push_back(16'h0000);
		send_frame(1'b0);
		check_value("status_req header", 128'(16'hA001), 128'(resp_words[0]));
		exp_status = status_in;
		for (int i = 1; i <= 8; i++) begin
			check_value("status_req slice", 128'(exp_status[15:0]), 128'(resp_words[i]));
			exp_status = exp_status >> 16;
		end

		////////////////////
		// keyboard
		////////////////////
		key_case("key 1C press", 32'h0000001C, 1, {1'b1, 1'b0, 8'h1C});
		key_case("key 1C release", 32'h0000F01C, 2, {1'b0, 1'b0, 8'h1C});
		key_case("print screen", 32'hE012E07C, 4, {1'b1, 1'b1, 8'h7C});
		key_case("print screen release", 32'h7CE0F012, 4, {1'b0, 1'b1, 8'h7C});
		key_case("pause", 32'hF014F077, 4, {1'b1, 1'b0, 8'h77});
		start_frame(hps_pkg::CMD_KBD);
		frame_words.push_back(16'h001C);
		frame_words.push_back(16'hFF00);
		send_frame(1'b0);
		check_value("skipped frame", 128'({key_toggle, 1'b1, 1'b0, 8'h77}), 128'(ps2_key));

		////////////////////
		// file download
		////////////////////
		start_frame(hps_pkg::CMD_FILE_INDEX);
		frame_words.push_back(16'h0003);
		send_frame(1'b1);
		check_value("file index", 128'(16'h0003), 128'(ioctl_index));
		start_frame(hps_pkg::CMD_FILE_TX);
		frame_words.push_back(16'h0001);
		frame_words.push_back(16'h0120);
		frame_words.push_back(16'h0000);
		send_frame(1'b1);
		check_value("download start", 128'(1'b1), 128'(ioctl_download));
		start_frame(hps_pkg::CMD_FILE_DAT);
		for (int i = 0; i < 5; i++) begin
			rw = random_word();
			frame_words.push_back({8'h00, rw[7:0]});
		end
		send_frame(1'b1);
		wait_writes(5);
		check_value("write count", 128'(5), 128'(wr_addr.size()));
		for (int i = 0; i < 5; i++) begin
			check_value("write address", 128'(27'h120 + 27'(i)), 128'(wr_addr[i]));
			check_value("write data", 128'(frame_words[i + 1][7:0]), 128'(wr_dout[i]));
		end
		start_frame(hps_pkg::CMD_FILE_TX);
		frame_words.push_back(16'h0000);
		send_frame(1'b1);
		check_value("download stop", 128'(1'b0), 128'(ioctl_download));
		start_frame(hps_pkg::CMD_FILE_DAT);
		frame_words.push_back(16'h005A);
		send_frame(1'b1);
		check_value("no write after stop", 128'(5), 128'(wr_addr.size()));

		end_run();
	end

endmodule

// ==== verif/hps_io_asserts.sv ====
// protocol checks for the command-port core, bound into hps_io_core
// assumes the host keeps frames apart and strobes at least 3 idle cycles apart
// failures are counted per property and summed in fail_count
module hps_io_asserts (
	input logic               clk_sys,
	input logic               arst_n,
	input hps_pkg::host_bus_s host,
	input hps_pkg::word_t     host_dout,
	input logic               ioctl_wr,
	input logic               ioctl_download,
	input logic               frame_end_valid,
	input logic               key_toggle
);

	int   wr_fails = 0;
	int   dl_fails = 0;
	int   dout_fails = 0;
	int   key_fails = 0;
	int   fail_count;
	logic idle;

	assign idle       = ~host.io_enable & ~host.fp_enable;
	assign fail_count = wr_fails + dl_fails + dout_fails + key_fails;

	////////////////////
	// download port
	////////////////////
	wr_single_cycle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wr |=> !ioctl_wr)
	else begin
		$error("ioctl_wr stayed high for two cycles");
		wr_fails++;
	end

	wr_in_download: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wr |-> ioctl_download)
	else begin
		$error("ioctl_wr pulsed outside a download");
		dl_fails++;
	end

	////////////////////
	// host side
	////////////////////
	// last response drains one cycle after the item is cleared
	dout_idle_zero: assert property (@(posedge clk_sys) disable iff (!arst_n)
		idle && $past(idle) && $past(idle, 2) |-> host_dout == '0)
	else begin
		$error("host_dout not zero with no frame open");
		dout_fails++;
	end

	toggle_after_end: assert property (@(posedge clk_sys) disable iff (!arst_n)
		key_toggle != $past(key_toggle) |-> $past(frame_end_valid))
	else begin
		$error("ps2_key toggle changed without a frame end");
		key_fails++;
	end

endmodule

bind hps_io_core hps_io_asserts hps_io_asserts_i (
	.clk_sys         (clk_sys),
	.arst_n          (arst_n),
	.host            (host),
	.host_dout       (host_dout),
	.ioctl_wr        (ioctl_wr),
	.ioctl_download  (ioctl_download),
	.frame_end_valid (frame_end.valid),
	.key_toggle      (ps2_key.toggle)
);

// ==== hw/hps_io_core.sv ====
// command-port core of the host I/O bridge
// strobe to any register output takes 2 cycles, frame drop to ps2_key 2 cycles
// no back-pressure: the host keeps at least 3 idle cycles between strobes
// DATA_W selects 8- or 16-bit download data
module hps_io_core #(
	parameter int DATA_W = 8
) (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  hps_pkg::host_bus_s host,
	output hps_pkg::word_t     host_dout,
	output hps_pkg::joy_t      joystick_0,
	output hps_pkg::joy_t      joystick_1,
	output hps_pkg::status_t   status,
	input  hps_pkg::status_t   status_in,
	input  logic               status_set,
	output hps_pkg::ps2_key_s  ps2_key,
	output logic               ioctl_download,
	output hps_pkg::word_t     ioctl_index,
	output logic               ioctl_wr,
	output logic [26:0]        ioctl_addr,
	output logic [DATA_W-1:0]  ioctl_dout
);

	hps_pkg::cmd_item_s  item;
	hps_pkg::frame_end_s frame_end;

	////////////////////
	// decode
	////////////////////
	cmd_decode cmd_decode_i (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.host      (host),
		.item      (item),
		.frame_end (frame_end)
	);

	////////////////////
	// execute
	////////////////////
	word_assembler #(.payload_t(hps_pkg::joy_t), .CMD(hps_pkg::CMD_JOY0)) joy0_asm_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.item    (item),
		.value   (joystick_0)
	);

	word_assembler #(.payload_t(hps_pkg::joy_t), .CMD(hps_pkg::CMD_JOY1)) joy1_asm_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.item    (item),
		.value   (joystick_1)
	);

	// 128-bit status, eight data words
	word_assembler #(.payload_t(hps_pkg::status_t), .CMD(hps_pkg::CMD_STATUS)) status_asm_i (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.item    (item),
		.value   (status)
	);

	ps2_key_decode ps2_key_decode_i (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.item      (item),
		.frame_end (frame_end),
		.ps2_key   (ps2_key)
	);

	file_loader #(.DATA_W(DATA_W)) file_loader_i (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.item           (item),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	////////////////////
	// result to host
	////////////////////
	status_readback status_readback_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.item       (item),
		.status_set (status_set),
		.status_in  (status_in),
		.host_dout  (host_dout)
	);

endmodule

// ==== hw/status_readback.sv ====
// status change request from the core, read back by the host with 0x29
// a rising status_set snapshots status_in and bumps a 4-bit request count
// 0x29 word 0 returns {4'hA, count}, words 1..8 the snapshot, low slice first
// host_dout holds between strobes of a 0x29 frame and is zero otherwise
module status_readback (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  hps_pkg::cmd_item_s item,
	input  logic               status_set,
	input  hps_pkg::status_t   status_in,
	output hps_pkg::word_t     host_dout
);

	logic             set_q;
	logic             set_rise;
	logic [3:0]       req_cnt;
	hps_pkg::status_t req_status;
	logic             req_frame;

	assign set_rise  = status_set & ~set_q;
	assign req_frame = ~item.file_frame & (item.cmd == hps_pkg::CMD_STATUS_REQ);

	always_ff @(posedge clk_sys) begin
		if (set_rise)
			req_status <= status_in;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			set_q     <= 1'b0;
			req_cnt   <= '0;
			host_dout <= '0;
		end else begin
			set_q <= status_set;
			if (set_rise)
				req_cnt <= req_cnt + 1'b1;

			// item fields drop to zero when the frame closes
			if (!req_frame) begin
				host_dout <= '0;
			end else if (item.valid) begin
				if (item.idx == '0)
					host_dout <= {4'hA, 8'h00, req_cnt};
				else if (item.idx <= 4'd8)
					host_dout <= req_status[16 * (int'(item.idx) - 1) +: 16];
				else
					host_dout <= '0;
			end
		end
	end

endmodule

// ==== hw/file_loader.sv ====
// host-to-core file download over file frames
// 0x55 word 1 is the file index, 0x53 word 1 nonzero starts and zero stops,
// 0x53 words 2/3 give the start address (27 bits), 0x54 words carry data
// DATA_W is 8 or 16; the address advances by DATA_W/8 per write
// ioctl_addr and ioctl_dout are only meaningful while ioctl_wr is high
module file_loader #(
	parameter int DATA_W = 8
) (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  hps_pkg::cmd_item_s item,
	output logic               ioctl_download,
	output hps_pkg::word_t     ioctl_index,
	output logic               ioctl_wr,
	output logic [26:0]        ioctl_addr,
	output logic [DATA_W-1:0]  ioctl_dout
);

	localparam logic [26:0] ADDR_STEP = 27'(DATA_W / 8);

	logic [26:0] addr;
	logic        file_item;
	logic        tx_item;
	logic        dat_wr;

	assign file_item = item.valid & item.file_frame;
	assign tx_item   = file_item & (item.cmd == hps_pkg::CMD_FILE_TX);

	// data word accepted only inside an active download
	assign dat_wr = file_item & (item.cmd == hps_pkg::CMD_FILE_DAT) &
		(item.idx != '0) & ioctl_download;

	////////////////////
	// download control
	////////////////////
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_download <= 1'b0;
			ioctl_wr       <= 1'b0;
			addr           <= '0;
		end else begin
			ioctl_wr <= dat_wr;
			if (dat_wr)
				addr <= addr + ADDR_STEP;

			if (tx_item) begin
				case (item.idx)
					4'd1: begin
						if (item.data != '0) begin
							ioctl_download <= 1'b1;
							addr           <= '0;
						end else begin
							ioctl_download <= 1'b0;
						end
					end
					4'd2: addr[15:0] <= item.data;
					4'd3: addr[26:16] <= item.data[10:0];
					default: ;
				endcase
			end
		end
	end

	////////////////////
	// write data and index
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (dat_wr) begin
			ioctl_addr <= addr;
			ioctl_dout <= item.data[DATA_W-1:0];
		end
		if (file_item && item.cmd == hps_pkg::CMD_FILE_INDEX && item.idx == 4'd1)
			ioctl_index <= item.data;
	end

endmodule

// ==== hw/ps2_key_decode.sv ====
// builds a key event from the scan bytes of a keyboard (0x05) frame
// the event is issued one cycle after frame_end; toggle flips per event
// a data word with high byte FF marks the whole frame as skipped
// only the last four scan bytes of a frame are kept
module ps2_key_decode (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  hps_pkg::cmd_item_s  item,
	input  hps_pkg::frame_end_s frame_end,
	output hps_pkg::ps2_key_s   ps2_key
);

	logic [31:0] raw;
	logic        skip;
	logic        kbd_item;
	logic        kbd_end;
	logic        pressed;
	logic        extended;

	assign kbd_item = item.valid & ~item.file_frame & (item.cmd == hps_pkg::CMD_KBD);
	assign kbd_end  = frame_end.valid & ~frame_end.file_frame &
		(frame_end.cmd == hps_pkg::CMD_KBD);

	// F0 as second-newest byte means release
	assign pressed  = (raw[15:8] != 8'hF0);
	assign extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			raw     <= '0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			////////////////////
			// byte collection
			////////////////////
			if (kbd_item) begin
				if (item.idx == '0) begin
					raw  <= '0;
					skip <= 1'b0;
				end else if (&item.data[15:8]) begin
					skip <= 1'b1;
				end else if (!skip) begin
					raw <= {raw[23:0], item.data[7:0]};
				end
			end

			////////////////////
			// event at frame close
			////////////////////
			if (kbd_end && !skip) begin
				ps2_key.toggle <= ~ps2_key.toggle;
				case (raw)
					// print screen release
					32'h7CE0F012: {ps2_key.pressed, ps2_key.extended, ps2_key.code} <= 10'h17C;
					// pause, press only
					32'hF014F077: {ps2_key.pressed, ps2_key.extended, ps2_key.code} <= 10'h277;
					default: begin
						ps2_key.pressed  <= pressed;
						ps2_key.extended <= extended;
						ps2_key.code     <= raw[7:0];
					end
				endcase
			end
		end
	end

endmodule

// ==== hw/word_assembler.sv ====
// collects the data words of one command into a payload register
// data word n lands in 16-bit slice n-1; words beyond the payload are dropped
// payload_t must be a packed type whose width is a multiple of 16
module word_assembler #(
	parameter type           payload_t = hps_pkg::joy_t,
	parameter hps_pkg::cmd_t CMD       = hps_pkg::CMD_JOY0
) (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  hps_pkg::cmd_item_s item,
	output payload_t           value
);

	localparam int PAYLOAD_W = $bits(payload_t);
	localparam int N_SLICES  = PAYLOAD_W / 16;

	logic [PAYLOAD_W-1:0] value_q;
	logic                 hit;

	// command frames only, and never the command word
	assign hit = item.valid & ~item.file_frame & (item.cmd == CMD) &
		(item.idx != '0) & (int'(item.idx) <= N_SLICES);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			value_q <= '0;
		else if (hit)
			value_q[16 * (int'(item.idx) - 1) +: 16] <= item.data;
	end

	assign value = payload_t'(value_q);

endmodule

// ==== hw/cmd_decode.sv ====
// splits host traffic into tagged items, one per strobe, one cycle later
// outside a strobe cycle the item keeps the fields of the last word of the open
// frame with valid low, and the whole item is zero while no frame is open
// frames must not overlap; an empty frame produces no frame_end pulse
module cmd_decode (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  hps_pkg::host_bus_s  host,
	output hps_pkg::cmd_item_s  item,
	output hps_pkg::frame_end_s frame_end
);

	logic                      active;
	logic                      active_q;
	logic                      file_q;
	hps_pkg::cmd_t             cmd_q;
	logic [hps_pkg::IDX_W-1:0] idx_q;

	assign active = host.io_enable | host.fp_enable;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			active_q  <= 1'b0;
			file_q    <= 1'b0;
			cmd_q     <= hps_pkg::cmd_t'(16'h0000);
			idx_q     <= '0;
			item      <= '0;
			frame_end <= '0;
		end else begin
			active_q <= active;

			// close pulse only for frames that carried a command word
			frame_end.valid      <= active_q & ~active & (idx_q != '0);
			frame_end.file_frame <= file_q;
			frame_end.cmd        <= cmd_q;

			item.valid <= 1'b0;
			if (!active) begin
				idx_q <= '0;
				item  <= '0;
			end else if (host.strobe) begin
				item.valid      <= 1'b1;
				item.file_frame <= host.fp_enable;
				item.idx        <= idx_q;
				item.data       <= host.din;
				if (idx_q == '0) begin
					cmd_q    <= hps_pkg::cmd_t'(host.din);
					item.cmd <= hps_pkg::cmd_t'(host.din);
					file_q   <= host.fp_enable;
				end else begin
					item.cmd <= cmd_q;
				end
				// saturating word count
				if (idx_q != '1)
					idx_q <= idx_q + 1'b1;
			end
		end
	end

endmodule

// ==== hw/hps_pkg.sv ====
// shared types for the host command-port bridge
// the host sends 16-bit words, framed by io_enable (command) or fp_enable (file)
// only the command codes listed in cmd_t are acted on, all others are ignored
package hps_pkg;

	// word index width, saturates at 15
	localparam int IDX_W = 4;

	typedef logic [15:0] word_t;

	////////////////////
	// command codes
	////////////////////
	typedef enum logic [15:0] {
		CMD_JOY0       = 16'h0002,
		CMD_JOY1       = 16'h0003,
		CMD_KBD        = 16'h0005,
		CMD_STATUS     = 16'h001E,
		CMD_STATUS_REQ = 16'h0029,
		CMD_FILE_TX    = 16'h0053,
		CMD_FILE_DAT   = 16'h0054,
		CMD_FILE_INDEX = 16'h0055
	} cmd_t;

	////////////////////
	// bus structs
	////////////////////
	typedef struct packed {
		logic  io_enable;
		logic  fp_enable;
		logic  strobe;
		word_t din;
	} host_bus_s;

	// one framed word, idx 0 is the command word itself
	typedef struct packed {
		logic             valid;
		logic             file_frame;
		cmd_t             cmd;
		logic [IDX_W-1:0] idx;
		word_t            data;
	} cmd_item_s;

	typedef struct packed {
		logic valid;
		logic file_frame;
		cmd_t cmd;
	} frame_end_s;

	typedef logic [31:0]  joy_t;
	typedef logic [127:0] status_t;

	// toggle flips once per key event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_s;

endpackage
